// ==== logic/mapper_pkg.sv ====
package mapper_pkg;

	localparam int BANK_SLOTS = 8; // Bank registers shared by all mappers

	typedef logic [7:0] bank_t; // One bank register

	// Mapper codes as written to $5xx6
	typedef enum logic [4:0] {
		MAP_NROM  = 5'd0, // Fixed 32 KB, UxROM group
		MAP_UXROM = 5'd1, // 16 KB switch, upper half fixed
		MAP_CNROM = 5'd2, // CHR switch only
		MAP_AXROM = 5'd8, // 32 KB switch, one-screen
		MAP_MMC3  = 5'd20 // Eight banks plus scanline IRQ
	} mapper_e;

	// Nametable A10 source
	typedef enum logic [1:0] {
		MIR_VERTICAL   = 2'd0, // A10 from PPU A10
		MIR_HORIZONTAL = 2'd1, // A10 from PPU A11
		MIR_ONE_A      = 2'd2, // Always low
		MIR_ONE_B      = 2'd3 // Always high
	} mirror_e;

	// Locked configuration, written at $5xx0-$5xx7
	typedef struct packed {
		logic [12:0] cpu_base;   // Flash A26-A14
		logic [4:0]  cpu_mask;   // Masks mapped A18-A14
		logic [4:0]  chr_mask;   // Masks mapped A17-A13
		logic [1:0]  sram_page;  // SRAM A14-A13
		mapper_e     mapper;
		logic        sram_enabled;
		logic        chr_write_enabled;
		logic        prg_write_enabled;
		mirror_e     mirroring;
		logic        lockout;    // Freezes the fields above
	} cart_cfg_t;

endpackage

// ==== logic/reg_write_if.sv ====
`timescale 1ns/1ps

interface reg_write_if
	import mapper_pkg::*;
();
	logic       wr_en;    // Write strobe, sampled on m2 rise
	logic [2:0] index;    // Target slot
	bank_t      data;
	logic       low_only; // Simple mappers keep 5 bits

	modport src (
		output wr_en, index, data, low_only
	);

	modport dst (
		input wr_en, index, data, low_only
	);

endinterface

// ==== logic/bank_view_if.sv ====
`timescale 1ns/1ps

interface bank_view_if
	import mapper_pkg::*;
();
	bank_t      values [BANK_SLOTS]; // One per slot
	logic       hit [BANK_SLOTS];    // CHR window hit per slot
	logic [2:0] window;              // PPU A12-A10
	logic       chr_invert;          // MMC3 CHR mode

	modport slot (
		output values, hit,
		input  window, chr_invert
	);

	modport sink (
		input values, hit
	);

endinterface

// ==== logic/cpu_reg_decoder.sv ====
`timescale 1ns/1ps

module cpu_reg_decoder
	import mapper_pkg::*;
(
	input  logic        m2,
	input  logic        rst,
	input  logic        romsel,
	input  logic        cpu_rw,
	input  logic [14:0] cpu_addr,
	input  bank_t       cpu_data,
	input  logic        reload_done, // Counter took the reload
	output cart_cfg_t   cfg,
	output logic [2:0]  bank_sel,
	output logic        prg_mode,
	output logic        chr_mode,
	output bank_t       irq_latch,
	output logic        irq_reload,
	output logic        irq_enable,
	reg_write_if.src    wr
);
	logic cfg_wr; // $5000-$5FFF while unlocked
	logic map_wr; // $8000-$FFFF

	assign cfg_wr = ~cpu_rw & romsel & (cpu_addr[14:12] == 3'b101) & ~cfg.lockout;
	assign map_wr = ~cpu_rw & ~romsel;

	// Bank register writes go out combinationally, slots latch on the edge
	always_comb
	begin
		wr.wr_en = 1'b0;
		wr.index = 3'd0;
		wr.data = cpu_data;
		wr.low_only = 1'b0;
		if (cfg_wr && cpu_addr[2:0] == 3'd3)
		begin
			wr.wr_en = 1'b1; // Direct slot 0 for NROM CHR
		end
		else if (cfg_wr && cpu_addr[2:0] == 3'd5)
		begin
			wr.wr_en = 1'b1; // Upper bits go to slot 1
			wr.index = 3'd1;
			wr.data = {2'b00, cpu_data[7:2]};
		end
		else if (map_wr)
		begin
			case (cfg.mapper)
				MAP_UXROM, MAP_AXROM:
				begin
					wr.wr_en = 1'b1; // PRG bank
					wr.index = 3'd1;
					wr.low_only = 1'b1;
				end
				MAP_CNROM:
				begin
					wr.wr_en = 1'b1; // CHR bank
					wr.low_only = 1'b1;
				end
				MAP_MMC3:
				begin
					wr.wr_en = (cpu_addr[14:13] == 2'b00) & cpu_addr[0]; // $8001 bank data
					wr.index = bank_sel;
				end
				default:
				begin
					wr.wr_en = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge m2 or posedge rst)
	begin
		if (rst)
		begin
			cfg <= '0;
			bank_sel <= 3'd0;
			prg_mode <= 1'b0;
			chr_mode <= 1'b0;
			irq_latch <= '0;
			irq_reload <= 1'b0;
			irq_enable <= 1'b0;
		end
		else
		begin
			if (reload_done)
				irq_reload <= 1'b0; // Consumed, a new write below wins
			if (cfg_wr)
			begin
				case (cpu_addr[2:0])
					3'd0: cfg.cpu_base[12:8] <= cpu_data[4:0]; // A26-A22
					3'd1: cfg.cpu_base[7:0] <= cpu_data;       // A21-A14
					3'd2: cfg.cpu_mask <= cpu_data[4:0];
					3'd4: cfg.chr_mask <= cpu_data[4:0];
					3'd5: cfg.sram_page <= cpu_data[1:0];
					3'd6: cfg.mapper <= mapper_e'(cpu_data[4:0]);
					3'd7:
					begin
						cfg.lockout <= cpu_data[7];
						cfg.mirroring <= mirror_e'(cpu_data[4:3]);
						cfg.prg_write_enabled <= cpu_data[2];
						cfg.chr_write_enabled <= cpu_data[1];
						cfg.sram_enabled <= cpu_data[0];
					end
					default: ; // $5xx3 handled as slot write
				endcase
			end
			if (map_wr && cfg.mapper == MAP_AXROM)
				cfg.mirroring <= mirror_e'({1'b1, cpu_data[4]}); // One-screen select
			if (map_wr && cfg.mapper == MAP_MMC3)
			begin
				case ({cpu_addr[14:13], cpu_addr[0]})
					3'b000:
					begin
						bank_sel <= cpu_data[2:0]; // $8000 even
						prg_mode <= cpu_data[6];
						chr_mode <= cpu_data[7];
					end
					3'b010: cfg.mirroring <= mirror_e'({1'b0, cpu_data[0]}); // $A000
					3'b100: irq_latch <= cpu_data; // $C000
					3'b101: irq_reload <= 1'b1;    // $C001
					3'b110: irq_enable <= 1'b0;    // $E000, also acks
					3'b111: irq_enable <= 1'b1;    // $E001
					default: ; // $8001 via slots, $A001 unused
				endcase
			end
		end
	end

endmodule

// ==== logic/chr_bank_slot.sv ====
`timescale 1ns/1ps

module chr_bank_slot
	import mapper_pkg::*;
#(
	parameter int SLOT = 0 // Position in the generate loop
)
(
	input  logic      m2,
	input  logic      rst,
	reg_write_if.dst  wr,
	bank_view_if.slot view
);
	localparam int SUB = (SLOT < 2) ? SLOT : SLOT - 2; // Window number inside its half

	bank_t value;
	logic  in_2k_half; // PPU address lies in the 2 KB half
	logic  hit;

	always_ff @(posedge m2 or posedge rst)
	begin
		if (rst)
			value <= '0;
		else if (wr.wr_en && wr.index == 3'(SLOT))
			value <= wr.low_only ? {3'b000, wr.data[4:0]} : wr.data;
	end

	assign in_2k_half = (view.window[2] == view.chr_invert);

	generate
		if (SLOT < 2)
		begin : g_2k
			assign hit = in_2k_half & (view.window[1] == 1'(SUB)); // R0, R1
		end
		else if (SLOT < 6)
		begin : g_1k
			assign hit = ~in_2k_half & (view.window[1:0] == 2'(SUB)); // R2-R5
		end
		else
		begin : g_prg
			assign hit = 1'b0; // R6, R7 are PRG only
		end
	endgenerate

	assign view.values[SLOT] = value;
	assign view.hit[SLOT] = hit;

endmodule

// ==== logic/addr_mapper.sv ====
`timescale 1ns/1ps

module addr_mapper
	import mapper_pkg::*;
(
	input  cart_cfg_t     cfg,
	input  logic          prg_mode,
	input  logic          chr_mode,
	input  logic          romsel,
	input  logic          m2,
	input  logic [14:0]   cpu_addr,
	input  logic [13:0]   ppu_addr,
	bank_view_if.sink     view,
	output logic [26:13]  cpu_addr_out,
	output logic [17:10]  ppu_addr_out,
	output logic          ppu_ciram_a10
);
	logic [18:13] prg_mapped; // Bank before base and mask
	logic [17:10] chr_mapped;
	bank_t        chr_bank;
	logic         chr_2k;     // MMC3 2 KB window active
	logic         sram_cycle; // $6000-$7FFF with m2 high

	// PRG bank select
	always_comb
	begin
		if (!cfg.mapper[4])
		begin
			if (!cfg.mapper[3])
				prg_mapped = {(cpu_addr[14] ? 5'b11111 : view.values[1][4:0]), cpu_addr[13]};
			else
				prg_mapped = {view.values[1][3:0], cpu_addr[14:13]}; // 32 KB
		end
		else
		begin
			case ({cpu_addr[14:13], prg_mode})
				3'b000, 3'b101: prg_mapped = view.values[6][5:0]; // R6 swaps with $C000
				3'b001, 3'b100: prg_mapped = 6'b111110;           // Second last
				3'b010, 3'b011: prg_mapped = view.values[7][5:0];
				default: prg_mapped = 6'b111111;                  // $E000 always last
			endcase
		end
	end

	// CHR bank select
	always_comb
	begin
		chr_2k = 1'b0;
		chr_bank = view.values[0]; // Simple mappers use slot 0
		if (cfg.mapper[4])
		begin
			chr_2k = (ppu_addr[12] == chr_mode);
			chr_bank = '0;
			for (int i = 0; i < BANK_SLOTS; i++)
			begin
				if (view.hit[i])
					chr_bank = view.values[i];
			end
		end
		if (!cfg.mapper[4])
			chr_mapped = {chr_bank[4:0], ppu_addr[12:10]}; // 8 KB
		else if (chr_2k)
			chr_mapped = {chr_bank[7:1], ppu_addr[10]}; // Even 1 KB pair
		else
			chr_mapped = chr_bank;
	end

	assign sram_cycle = romsel & m2 & cpu_addr[14] & cpu_addr[13];

	// ROM gets base plus masked bank, otherwise SRAM page in A14-A13
	assign cpu_addr_out = !romsel ?
		{cfg.cpu_base | {8'd0, prg_mapped[18:14] & ~cfg.cpu_mask}, prg_mapped[13]} :
		{12'd0, (sram_cycle ? cfg.sram_page : 2'b00)};

	assign ppu_addr_out = {chr_mapped[17:13] & ~cfg.chr_mask, chr_mapped[12:10]};

	always_comb
	begin
		case (cfg.mirroring)
			MIR_VERTICAL:   ppu_ciram_a10 = ppu_addr[10];
			MIR_HORIZONTAL: ppu_ciram_a10 = ppu_addr[11];
			MIR_ONE_A:      ppu_ciram_a10 = 1'b0;
			default:        ppu_ciram_a10 = 1'b1;
		endcase
	end

endmodule

// ==== logic/scanline_irq.sv ====
`timescale 1ns/1ps

module scanline_irq
	import mapper_pkg::*;
#(
	parameter int A12_LOW_CYCLES = 3 // m2 rises A12 must stay low
)
(
	input  logic  m2,
	input  logic  rst,
	input  logic  a12,
	input  bank_t irq_latch,
	input  logic  irq_reload,
	input  logic  irq_enable,
	output logic  reload_done, // Pending reload taken this edge
	output logic  irq          // Active low
);
	localparam int LW = $clog2(A12_LOW_CYCLES + 1);

	logic [LW-1:0] low_time; // Saturating low sample count
	logic          a12_prev;
	bank_t         counter;
	bank_t         counter_next;
	logic          irq_flag;
	logic          count_rise;

	// Rise only counts after a long enough low period
	assign count_rise = a12 & ~a12_prev & (low_time == LW'(A12_LOW_CYCLES));
	assign reload_done = count_rise & irq_reload;

	always_comb
	begin
		if (counter == 8'd0 || irq_reload)
			counter_next = irq_latch;
		else
			counter_next = counter - 8'd1;
	end

	always_ff @(posedge m2 or posedge rst)
	begin
		if (rst)
		begin
			low_time <= '0;
			a12_prev <= 1'b0;
			counter <= '0;
			irq_flag <= 1'b0;
		end
		else
		begin
			a12_prev <= a12;
			if (a12)
				low_time <= '0;
			else if (low_time != LW'(A12_LOW_CYCLES))
				low_time <= low_time + 1'b1;
			if (count_rise)
			begin
				counter <= counter_next;
				if (counter_next == 8'd0 && irq_enable)
					irq_flag <= 1'b1;
			end
			if (!irq_enable)
				irq_flag <= 1'b0; // Ack and mask
		end
	end

	assign irq = ~(irq_flag & irq_enable);

endmodule

// ==== logic/cart_mapper.sv ====
`timescale 1ns/1ps

module cart_mapper
	import mapper_pkg::*;
#(
	parameter int A12_LOW_CYCLES = 3
)
(
	input  logic         m2,
	input  logic         ppu_addr_in, // Async reset, active high
	input  logic         romsel,
	input  logic         cpu_rw,
	input  logic [14:0]  cpu_addr,
	input  logic [7:0]   cpu_data,
	input  logic         ppu_rd,
	input  logic         ppu_wr,
	input  logic [13:0]  ppu_addr,
	output logic [26:13] cpu_addr_out,
	output logic         flash_we,
	output logic         flash_oe,
	output logic         sram_ce,
	output logic         sram_we,
	output logic         sram_oe,
	output logic [17:10] ppu_addr_out,
	output logic         ppu_rd_out,
	output logic         ppu_wr_out,
	output logic         ppu_ciram_a10,
	output logic         irq
);
	cart_cfg_t  cfg;
	logic [2:0] bank_sel;
	logic       prg_mode;
	logic       chr_mode;
	bank_t      irq_latch;
	logic       irq_reload;
	logic       irq_enable;
	logic       reload_done;

	reg_write_if wr_bus();
	bank_view_if view_bus();

	cpu_reg_decoder i_decoder (
		.m2, .rst(ppu_addr_in), .romsel, .cpu_rw, .cpu_addr, .cpu_data, .reload_done,
		.cfg, .bank_sel, .prg_mode, .chr_mode, .irq_latch, .irq_reload, .irq_enable,
		.wr(wr_bus)
	);

	assign view_bus.window = ppu_addr[12:10];
	assign view_bus.chr_invert = chr_mode;

	for (genvar i = 0; i < BANK_SLOTS; i++)
	begin : g_slot
		chr_bank_slot #(.SLOT(i)) i_slot (
			.m2, .rst(ppu_addr_in), .wr(wr_bus), .view(view_bus)
		);
	end

	addr_mapper i_addr_mapper (
		.cfg, .prg_mode, .chr_mode, .romsel, .m2, .cpu_addr, .ppu_addr, .view(view_bus),
		.cpu_addr_out, .ppu_addr_out, .ppu_ciram_a10
	);

	scanline_irq #(.A12_LOW_CYCLES(A12_LOW_CYCLES)) i_scanline_irq (
		.m2, .rst(ppu_addr_in), .a12(ppu_addr[12]), .irq_latch, .irq_reload, .irq_enable,
		.reload_done, .irq
	);

	// Strobes are all active low
	assign flash_we = cpu_rw | romsel | ~cfg.prg_write_enabled; // Flash writes only when enabled
	assign flash_oe = ~cpu_rw | romsel;
	assign sram_ce = ~(cpu_addr[14] & cpu_addr[13] & m2 & romsel & cfg.sram_enabled);
	assign sram_we = cpu_rw;
	assign sram_oe = ~cpu_rw;
	assign ppu_rd_out = ppu_rd | ppu_addr[13]; // Pattern space only
	assign ppu_wr_out = ppu_wr | ppu_addr[13] | ~cfg.chr_write_enabled;

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD = 10,     // ns
	parameter int RESET_CYCLES = 2
)
(
	output logic m2,
	output logic rst
);
	initial
	begin
		m2 = 1'b0;
		forever #(PERIOD / 2) m2 = ~m2; // Free-running CPU clock
	end

	initial
	begin
		rst = 1'b1; // Power-on reset
		repeat (RESET_CYCLES) @(posedge m2);
		@(negedge m2);
		rst = 1'b0;
	end

endmodule

// ==== verification/cart_mapper_sva.sv ====
`timescale 1ns/1ps

module cart_mapper_sva (
	input logic         m2,
	input logic         rst,
	input logic         irq,
	input logic         irq_enable,
	input logic         flash_we,
	input logic         flash_oe,
	input logic         prg_write_enabled,
	input logic         lockout,
	input logic         sram_ce,
	input logic [1:0]   sram_page,
	input logic [26:13] cpu_addr_out
);
	// A disabled IRQ is also acknowledged
	a_irq_masked: assert property (@(posedge m2) disable iff (rst) !irq_enable |=> irq)
		else $error("irq low after the IRQ was disabled");

	// Locked with PRG writes off stays that way
	a_flash_we_locked: assert property (@(posedge m2) disable iff (rst)
		lockout && !prg_write_enabled |=> !prg_write_enabled && flash_we)
		else $error("flash writes enabled while the config is locked");

	// Falling edge sees m2 high, where an SRAM cycle can be active
	a_sram_flash_excl: assert property (@(negedge m2) disable iff (rst)
		!sram_ce |-> flash_oe && flash_we && cpu_addr_out[14:13] == sram_page)
		else $error("sram_ce active with flash strobes or without the SRAM page");

endmodule

bind cart_mapper cart_mapper_sva i_cart_mapper_sva (
	.m2, .rst(ppu_addr_in), .irq, .irq_enable, .flash_we, .flash_oe,
	.prg_write_enabled(cfg.prg_write_enabled), .lockout(cfg.lockout), .sram_ce,
	.sram_page(cfg.sram_page), .cpu_addr_out
);

// ==== verification/cart_mapper_tb.sv ====
`timescale 1ns/1ps

module cart_mapper_tb
	import mapper_pkg::*;
();
	localparam int A12_LOW = 3;   // Low samples before an A12 rise counts
	localparam int RST_WAIT = 20; // Cycles allowed for reset release
	localparam int IRQ_WAIT = 8;  // Cycles allowed for irq to fall

	logic         m2;
	logic         gen_rst; // Power-on pulse
	logic         rst_req; // Reset between tests
	logic         rst;
	logic         romsel;
	logic         cpu_rw;
	logic [14:0]  cpu_addr;
	logic [7:0]   cpu_data;
	logic         ppu_rd;
	logic         ppu_wr;
	logic [13:0]  ppu_addr;
	logic [26:13] cpu_addr_out;
	logic         flash_we;
	logic         flash_oe;
	logic         sram_ce;
	logic         sram_we;
	logic         sram_oe;
	logic [17:10] ppu_addr_out;
	logic         ppu_rd_out;
	logic         ppu_wr_out;
	logic         ppu_ciram_a10;
	logic         irq;
	bank_t        banks [BANK_SLOTS]; // MMC3 values written
	int           checks;
	int           errors;
	bit           hung;

	assign rst = gen_rst | rst_req;

	tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(2)) i_clock_gen (.m2, .rst(gen_rst));

	cart_mapper #(.A12_LOW_CYCLES(A12_LOW)) i_cart_mapper (
		.m2, .ppu_addr_in(rst), .romsel, .cpu_rw, .cpu_addr, .cpu_data, .ppu_rd, .ppu_wr,
		.ppu_addr, .cpu_addr_out, .flash_we, .flash_oe, .sram_ce, .sram_we, .sram_oe,
		.ppu_addr_out, .ppu_rd_out, .ppu_wr_out, .ppu_ciram_a10, .irq
	);

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// Base ORed with the masked 16 KB bank, A13 passes
	function automatic logic [26:13] prg_addr(input logic [12:0] base, input logic [4:0] mask,
		input logic [4:0] bank, input logic a13);
		return {base | {8'd0, bank & ~mask}, a13};
	endfunction

	// 8 KB MMC3 PRG bank per CPU window
	function automatic logic [5:0] mmc3_prg(input logic [1:0] win, input logic mode);
		case (win)
			2'd0: return mode ? 6'h3E : banks[6][5:0];
			2'd1: return banks[7][5:0];
			2'd2: return mode ? banks[6][5:0] : 6'h3E;
			default: return 6'h3F;
		endcase
	endfunction

	// 1 KB MMC3 CHR page, 2 KB half picked by chr_mode
	function automatic bank_t mmc3_chr(input logic [2:0] win, input logic mode);
		if (win[2] == mode)
			return {(win[1] ? banks[1][7:1] : banks[0][7:1]), win[0]};
		return banks[int'(win[1:0]) + 2];
	endfunction

	task automatic idle_inputs();
		romsel = 1'b1;
		cpu_rw = 1'b1;
		cpu_addr = '0;
		cpu_data = '0;
		ppu_rd = 1'b1;
		ppu_wr = 1'b1;
		ppu_addr = '0;
	endtask

	task automatic reset_dut();
		int wait_cycles;
		@(negedge m2);
		idle_inputs();
		rst_req = 1'b1;
		repeat (2) @(negedge m2);
		rst_req = 1'b0;
		wait_cycles = 0;
		while (rst && wait_cycles < RST_WAIT)
		begin
			@(negedge m2);
			wait_cycles++;
		end
		if (rst)
		begin
			hung = 1'b1;
			$display("Timeout: reset still active after %0d cycles", RST_WAIT);
		end
	endtask

	task automatic cpu_write(input logic [14:0] addr, input logic rs, input bank_t data);
		@(negedge m2);
		romsel = rs;
		cpu_addr = addr;
		cpu_data = data;
		cpu_rw = 1'b0;
		@(negedge m2); // Taken on the rise between
		cpu_rw = 1'b1;
		romsel = 1'b1;
	endtask

	task automatic cfg_write(input logic [2:0] idx, input bank_t data);
		cpu_write({3'b101, 9'd0, idx}, 1'b1, data); // $5xx0-$5xx7
	endtask

	task automatic cpu_read(input logic [14:0] addr, input logic [26:13] exp, input string what);
		@(negedge m2);
		romsel = 1'b0;
		cpu_rw = 1'b1;
		cpu_addr = addr;
		#1;
		expect_eq(what, 32'(cpu_addr_out), 32'(exp));
	endtask

	task automatic ppu_read(input logic [13:0] addr, input bank_t exp, input string what);
		@(negedge m2);
		ppu_addr = addr;
		#1;
		expect_eq(what, 32'(ppu_addr_out), 32'(exp));
	endtask

	task automatic a10_read(input logic [13:0] addr, input logic exp, input string what);
		@(negedge m2);
		ppu_addr = addr;
		#1;
		expect_eq(what, 32'(ppu_ciram_a10), 32'(exp));
	endtask

	// Low for low_cycles rises, then high across one rise
	task automatic a12_pulse(input int low_cycles);
		@(negedge m2);
		ppu_addr[12] = 1'b0;
		repeat (low_cycles) @(negedge m2);
		ppu_addr[12] = 1'b1;
		@(negedge m2);
		#1;
	endtask

	task automatic verify_reset_state();
		@(negedge m2);
		cpu_addr = 15'h6000; // SRAM window, m2 high below
		@(posedge m2);
		#1;
		expect_eq("irq after reset", 32'(irq), 32'd1);
		expect_eq("flash_we after reset", 32'(flash_we), 32'd1);
		expect_eq("sram_ce after reset", 32'(sram_ce), 32'd1);
		cpu_read(15'h0000, prg_addr(13'd0, 5'd0, 5'd0, 1'b0), "NROM $8000 after reset");
	endtask

	task automatic lockout_config();
		logic [12:0] base;
		logic [4:0]  mask;
		base = 13'($urandom);
		mask = 5'($urandom);
		cfg_write(3'd0, {3'b000, base[12:8]});
		cfg_write(3'd1, base[7:0]);
		cfg_write(3'd2, {3'b000, mask});
		cfg_write(3'd6, 8'(MAP_UXROM));
		cfg_write(3'd7, 8'h80); // Lockout on
		cpu_read(15'h4000, prg_addr(base, mask, 5'h1F, 1'b0), "masked base at $C000");
		cpu_read(15'h0000, prg_addr(base, mask, 5'h00, 1'b0), "masked base at $8000");
		cfg_write(3'd1, ~base[7:0]);
		cfg_write(3'd2, 8'h00);
		cfg_write(3'd7, 8'h04); // Flash writes stay off
		cpu_read(15'h4000, prg_addr(base, mask, 5'h1F, 1'b0), "config write after lockout");
	endtask

	task automatic simple_mappers();
		bank_t       bank;
		bank_t       chr;
		logic [4:0]  cmask;
		logic [13:0] pa;
		bank = 8'($urandom);
		cfg_write(3'd6, 8'(MAP_UXROM));
		cpu_write(15'h0000, 1'b0, bank);
		cpu_read(15'h0000, prg_addr(13'd0, 5'd0, bank[4:0], 1'b0), "UxROM $8000");
		cpu_read(15'h2000, prg_addr(13'd0, 5'd0, bank[4:0], 1'b1), "UxROM $A000");
		cpu_read(15'h4000, prg_addr(13'd0, 5'd0, 5'h1F, 1'b0), "UxROM $C000 last bank");
		chr = 8'($urandom);
		cmask = 5'($urandom);
		pa = 14'($urandom) & 14'h1FFF; // Pattern space
		cfg_write(3'd4, {3'b000, cmask});
		cfg_write(3'd6, 8'(MAP_CNROM));
		cpu_write(15'h0000, 1'b0, chr);
		ppu_read(pa, {chr[4:0] & ~cmask, pa[12:10]}, "CNROM CHR bank");
		cfg_write(3'd6, 8'(MAP_AXROM));
		cpu_write(15'h0000, 1'b0, bank | 8'h10); // Screen B
		cpu_read(15'h4000, prg_addr(13'd0, 5'd0, {bank[3:0], 1'b1}, 1'b0), "AxROM $C000");
		a10_read(14'h0000, 1'b1, "AxROM one-screen B");
		cpu_write(15'h0000, 1'b0, bank & 8'hEF);
		a10_read(14'h0C00, 1'b0, "AxROM one-screen A");
	endtask

	task automatic mmc3_banking();
		logic [1:0]  modes;
		logic [5:0]  bank6;
		logic [13:0] pa;
		cfg_write(3'd6, 8'(MAP_MMC3));
		for (int r = 0; r < BANK_SLOTS; r++)
		begin
			banks[r] = 8'($urandom);
			cpu_write(15'h0000, 1'b0, 8'(r)); // Select R0-R7
			cpu_write(15'h0001, 1'b0, banks[r]);
		end
		for (int m = 0; m < 4; m++)
		begin
			modes = 2'(m); // chr_mode, prg_mode
			cpu_write(15'h0000, 1'b0, {modes, 6'd0});
			for (int w = 0; w < 4; w++)
			begin
				bank6 = mmc3_prg(2'(w), modes[0]);
				cpu_read({2'(w), 13'd0}, prg_addr(13'd0, 5'd0, bank6[5:1], bank6[0]),
					"MMC3 PRG window");
			end
			for (int w = 0; w < 8; w++)
			begin
				pa = {1'b0, 3'(w), 10'($urandom)};
				ppu_read(pa, mmc3_chr(3'(w), modes[1]), "MMC3 CHR window");
			end
		end
		cpu_write(15'h2000, 1'b0, 8'h00); // Vertical
		a10_read(14'h0400, 1'b1, "MMC3 vertical A10");
		a10_read(14'h0800, 1'b0, "MMC3 vertical A11");
		cpu_write(15'h2000, 1'b0, 8'h01); // Horizontal
		a10_read(14'h0400, 1'b0, "MMC3 horizontal A10");
		a10_read(14'h0800, 1'b1, "MMC3 horizontal A11");
	endtask

	task automatic scanline_count();
		int n;
		int wait_cycles;
		n = int'($urandom_range(5, 1));
		cfg_write(3'd6, 8'(MAP_MMC3));
		cpu_write(15'h4000, 1'b0, 8'(n));  // Latch
		cpu_write(15'h4001, 1'b0, 8'h00);  // Reload
		cpu_write(15'h6001, 1'b0, 8'h00);  // Enable
		for (int k = 1; k <= n; k++)
		begin
			a12_pulse(A12_LOW);
			expect_eq("irq before latch+1 rises", 32'(irq), 32'd1);
			if (k == 1)
			begin
				a12_pulse(A12_LOW - 1); // Too short to count
				expect_eq("irq after short A12 low", 32'(irq), 32'd1);
			end
		end
		a12_pulse(A12_LOW);
		wait_cycles = 0;
		while (irq && wait_cycles < IRQ_WAIT)
		begin
			@(negedge m2); // A12 stays high, no further rise
			wait_cycles++;
		end
		expect_eq("irq after latch+1 rises", 32'(irq), 32'd0);
		cpu_write(15'h6000, 1'b0, 8'h00); // Ack
		#1;
		expect_eq("irq after $E000 write", 32'(irq), 32'd1);
	endtask

	task automatic strobe_rules();
		for (int en = 0; en < 2; en++)
		begin
			cfg_write(3'd5, 8'(en + 1)); // SRAM page 1, then 2
			cfg_write(3'd7, en ? 8'h07 : 8'h00); // PRG, CHR, SRAM enables
			@(negedge m2);
			romsel = 1'b0;
			cpu_rw = 1'b1;
			ppu_rd = 1'b0;
			ppu_wr = 1'b0;
			ppu_addr = 14'h0123;
			#1;
			expect_eq("flash_oe on ROM read", 32'(flash_oe), 32'd0);
			expect_eq("flash_we on ROM read", 32'(flash_we), 32'd1);
			expect_eq("ppu_rd_out in pattern space", 32'(ppu_rd_out), 32'd0);
			expect_eq("ppu_wr_out in pattern space", 32'(ppu_wr_out), 32'(en == 0));
			@(negedge m2);
			cpu_rw = 1'b0; // NROM ignores the write
			ppu_addr = 14'h2123;
			#1;
			expect_eq("flash_we on ROM write", 32'(flash_we), 32'(en == 0));
			expect_eq("flash_oe on ROM write", 32'(flash_oe), 32'd1);
			expect_eq("ppu_rd_out in nametables", 32'(ppu_rd_out), 32'd1);
			expect_eq("ppu_wr_out in nametables", 32'(ppu_wr_out), 32'd1);
			@(negedge m2);
			romsel = 1'b1;
			cpu_rw = 1'b1;
			cpu_addr = 15'h6000;
			ppu_rd = 1'b1;
			ppu_wr = 1'b1;
			@(posedge m2);
			#1;
			expect_eq("sram_ce in SRAM cycle", 32'(sram_ce), 32'(en == 0));
			expect_eq("flash_oe in SRAM cycle", 32'(flash_oe), 32'd1);
			expect_eq("sram_oe on SRAM read", 32'(sram_oe), 32'd0);
			expect_eq("sram_we on SRAM read", 32'(sram_we), 32'd1);
			expect_eq("SRAM page on A14-A13", 32'(cpu_addr_out[14:13]), 32'(en + 1));
			@(negedge m2);
			cpu_rw = 1'b0; // SRAM write, outside the config window
			@(posedge m2);
			#1;
			expect_eq("sram_we on SRAM write", 32'(sram_we), 32'd0);
			expect_eq("sram_oe on SRAM write", 32'(sram_oe), 32'd1);
		end
	endtask

	initial
	begin
		void'($urandom(41));
		checks = 0;
		errors = 0;
		hung = 1'b0;
		rst_req = 1'b0;
		idle_inputs();
		for (int t = 0; t < 6 && !hung; t++)
		begin
			reset_dut(); // Fresh config, lockout cleared
			if (!hung)
			begin
				case (t)
					0: verify_reset_state();
					1: lockout_config();
					2: simple_mappers();
					3: mmc3_banking();
					4: scanline_count();
					default: strobe_rules();
				endcase
			end
		end
		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, hung);
		if (errors == 0 && !hung)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/mapper_pkg.sv
logic/reg_write_if.sv
logic/bank_view_if.sv
logic/cpu_reg_decoder.sv
logic/chr_bank_slot.sv
logic/addr_mapper.sv
logic/scanline_irq.sv
logic/cart_mapper.sv
verification/tb_clock_gen.sv
verification/cart_mapper_sva.sv
verification/cart_mapper_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cart_mapper_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
